// ==== include/flow_table_defs.svh ====
`ifndef FLOW_TABLE_DEFS_SVH
`define FLOW_TABLE_DEFS_SVH

// Table geometry
`define FT_WAYS        4
`define FT_AWIDTH      4
`define FT_DEPTH       16

// Field widths
`define FT_TUPLE_W     104
`define FT_PCIE_W      64
`define FT_LEN_W       16

// Hash pipeline
`define FT_HASH_W      32
`define FT_HASH_STAGES 4
`define FT_HASH_MULT   32'h9e3779b1

// Edges from read enable to subtable data
`define FT_READ_LAT    2

`endif

// ==== hw/flow_fields_pkg.sv ====
`include "flow_table_defs.svh"

package flow_fields_pkg;

    // Src IP, dst IP, src port, dst port, protocol
    typedef logic [`FT_TUPLE_W-1:0] tuple_t;

    typedef logic [`FT_PCIE_W-1:0] pcie_addr_t;
    typedef logic [`FT_LEN_W-1:0]  pkt_len_t;

endpackage

// ==== hw/flow_table_pkg.sv ====
`include "flow_table_defs.svh"

package flow_table_pkg;

    typedef logic [`FT_HASH_W-1:0] hash_t;
    typedef logic [`FT_AWIDTH-1:0] ft_addr_t;

    // One bit per subtable
    typedef logic [`FT_WAYS-1:0] way_mask_t;

    typedef enum logic {
        LK_IDLE,
        LK_READ
    } lookup_state_t;

    typedef enum logic [2:0] {
        PL_IDLE,
        PL_READ,
        PL_UPDATE,
        PL_INSERT,
        PL_FULL
    } place_state_t;

endpackage

// ==== hw/flow_hash.sv ====
`timescale 1ns/1ps
`include "flow_table_defs.svh"

module flow_hash #(
    parameter int SEED = 0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  flow_fields_pkg::tuple_t tuple_in,
    input  logic                    tuple_valid,
    output flow_table_pkg::hash_t   hashed,
    output logic                    hashed_valid
);

    import flow_table_pkg::*;

    localparam int PAD_W = 4 * `FT_HASH_W;

    logic [PAD_W-1:0]           padded;
    hash_t                      folded;
    hash_t                      s1_fold;
    hash_t                      s2_mul;
    hash_t                      s3_mix;
    logic [`FT_HASH_STAGES-1:0] stage_valid;

    // Zero-padded tuple folded into one word with the seed
    assign padded = {{(PAD_W - `FT_TUPLE_W){1'b0}}, tuple_in};
    assign folded = padded[0 +: `FT_HASH_W] ^ padded[`FT_HASH_W +: `FT_HASH_W]
                  ^ padded[2*`FT_HASH_W +: `FT_HASH_W] ^ padded[3*`FT_HASH_W +: `FT_HASH_W]
                  ^ hash_t'(SEED);

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_fold <= folded;
            s2_mul  <= s1_fold * `FT_HASH_MULT;
            s3_mix  <= s2_mul ^ (s2_mul >> 16);
            hashed  <= s3_mix * `FT_HASH_MULT;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= '0;
        end else if (!stall) begin
            stage_valid <= {stage_valid[`FT_HASH_STAGES-2:0], tuple_valid};
        end
    end

    assign hashed_valid = stage_valid[`FT_HASH_STAGES-1];

endmodule

// ==== hw/flow_subtable.sv ====
`timescale 1ns/1ps
`include "flow_table_defs.svh"

module flow_subtable (
    input  logic                        clk,
    input  logic                        rst,
    input  flow_table_pkg::ft_addr_t    addr_a,
    input  flow_table_pkg::ft_addr_t    addr_b,
    input  logic                        rd_en_a,
    input  logic                        rd_en_b,
    input  logic                        wr_en_b,
    input  flow_fields_pkg::tuple_t     wr_tuple,
    input  flow_fields_pkg::pcie_addr_t wr_pcie_addr,
    output logic                        q_a_valid,
    output logic                        q_b_valid,
    output flow_fields_pkg::tuple_t     q_a_tuple,
    output flow_fields_pkg::tuple_t     q_b_tuple,
    output flow_fields_pkg::pcie_addr_t q_a_pcie_addr,
    output flow_fields_pkg::pcie_addr_t q_b_pcie_addr
);

    import flow_fields_pkg::*;
    import flow_table_pkg::*;

    tuple_t               mem_tuple [`FT_DEPTH];
    pcie_addr_t           mem_pcie [`FT_DEPTH];
    logic [`FT_DEPTH-1:0] slot_valid;
    ft_addr_t             addr_a_r;
    ft_addr_t             addr_b_r;
    logic                 rd_a_r;
    logic                 rd_b_r;

    always_ff @(posedge clk) begin
        if (wr_en_b) begin
            mem_tuple[addr_b] <= wr_tuple;
            mem_pcie[addr_b]  <= wr_pcie_addr;
        end
    end

    // Table starts empty
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid <= '0;
        end else if (wr_en_b) begin
            slot_valid[addr_b] <= 1'b1;
        end
    end

    // First read cycle registers the address
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_a_r <= 1'b0;
            rd_b_r <= 1'b0;
        end else begin
            rd_a_r <= rd_en_a;
            rd_b_r <= rd_en_b;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_a) begin
            addr_a_r <= addr_a;
        end
        if (rd_en_b) begin
            addr_b_r <= addr_b;
        end
    end

    // Second read cycle registers the data
    always_ff @(posedge clk) begin
        if (rst) begin
            q_a_valid <= 1'b0;
            q_b_valid <= 1'b0;
        end else begin
            if (rd_a_r) begin
                q_a_valid <= slot_valid[addr_a_r];
            end
            if (rd_b_r) begin
                q_b_valid <= slot_valid[addr_b_r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_a_r) begin
            q_a_tuple     <= mem_tuple[addr_a_r];
            q_a_pcie_addr <= mem_pcie[addr_a_r];
        end
        if (rd_b_r) begin
            q_b_tuple     <= mem_tuple[addr_b_r];
            q_b_pcie_addr <= mem_pcie[addr_b_r];
        end
    end

endmodule

// ==== hw/flow_lookup.sv ====
`timescale 1ns/1ps
`include "flow_table_defs.svh"

module flow_lookup (
    input  logic                        clk,
    input  logic                        rst,
    input  flow_fields_pkg::tuple_t     in_meta_tuple,
    input  flow_fields_pkg::pkt_len_t   in_meta_len,
    input  logic                        in_meta_valid,
    output logic                        in_meta_ready,
    output flow_fields_pkg::tuple_t     out_meta_tuple,
    output flow_fields_pkg::pkt_len_t   out_meta_len,
    output flow_fields_pkg::pcie_addr_t out_meta_pcie_addr,
    output logic                        out_meta_valid,
    output logic                        rd_en_a,
    output flow_table_pkg::ft_addr_t    addr_a [`FT_WAYS],
    input  flow_table_pkg::way_mask_t   q_a_valid,
    input  flow_fields_pkg::tuple_t     q_a_tuple [`FT_WAYS],
    input  flow_fields_pkg::pcie_addr_t q_a_pcie_addr [`FT_WAYS]
);

    import flow_fields_pkg::*;
    import flow_table_pkg::*;

    localparam int               CNT_W   = $clog2(`FT_READ_LAT + 1);
    localparam logic [CNT_W-1:0] RD_LAST = CNT_W'(`FT_READ_LAT);

    lookup_state_t    state;
    logic             busy;
    logic             issue;
    logic             finish;
    logic [CNT_W-1:0] rd_cnt;
    hash_t            hashed [`FT_WAYS];
    way_mask_t        hashed_valid;
    tuple_t           meta_tuple_d [`FT_HASH_STAGES];
    pkt_len_t         meta_len_d [`FT_HASH_STAGES];
    way_mask_t        hit;
    pcie_addr_t       hit_addr;

    assign busy          = (state == LK_READ);
    assign in_meta_ready = (state == LK_IDLE);
    assign issue         = in_meta_ready && (&hashed_valid);
    assign finish        = busy && (rd_cnt == RD_LAST);

    for (genvar w = 0; w < `FT_WAYS; w++) begin : g_way
        flow_hash #(.SEED(w)) hash_i (
            .clk          (clk),
            .rst          (rst),
            .stall        (busy),
            .tuple_in     (in_meta_tuple),
            .tuple_valid  (in_meta_valid && in_meta_ready),
            .hashed       (hashed[w]),
            .hashed_valid (hashed_valid[w])
        );
        assign hit[w] = q_a_valid[w] && (q_a_tuple[w] == out_meta_tuple);
    end

    // Metadata moves in step with the hash stages
    always_ff @(posedge clk) begin
        if (!busy) begin
            meta_tuple_d[0] <= in_meta_tuple;
            meta_len_d[0]   <= in_meta_len;
            for (int i = 1; i < `FT_HASH_STAGES; i++) begin
                meta_tuple_d[i] <= meta_tuple_d[i-1];
                meta_len_d[i]   <= meta_len_d[i-1];
            end
        end
    end

    // Lowest hit way wins, zero on a miss means drop
    always_comb begin
        hit_addr = '0;
        for (int w = `FT_WAYS - 1; w >= 0; w--) begin
            if (hit[w]) begin
                hit_addr = q_a_pcie_addr[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= LK_IDLE;
            rd_en_a        <= 1'b0;
            out_meta_valid <= 1'b0;
            rd_cnt         <= '0;
        end else begin
            rd_en_a        <= issue;
            out_meta_valid <= finish;
            if (issue) begin
                rd_cnt <= '0;
                state  <= LK_READ;
            end else if (finish) begin
                state <= LK_IDLE;
            end else if (busy) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    // Tuple and length are held from issue until the result pulse
    always_ff @(posedge clk) begin
        if (issue) begin
            out_meta_tuple <= meta_tuple_d[`FT_HASH_STAGES-1];
            out_meta_len   <= meta_len_d[`FT_HASH_STAGES-1];
            for (int w = 0; w < `FT_WAYS; w++) begin
                addr_a[w] <= hashed[w][`FT_HASH_W-1 -: `FT_AWIDTH];
            end
        end
        if (finish) begin
            out_meta_pcie_addr <= hit_addr;
        end
    end

endmodule

// ==== hw/flow_placement.sv ====
`timescale 1ns/1ps
`include "flow_table_defs.svh"

module flow_placement (
    input  logic                        clk,
    input  logic                        rst,
    input  flow_fields_pkg::tuple_t     in_control_tuple,
    input  flow_fields_pkg::pcie_addr_t in_control_pcie_addr,
    input  logic                        in_control_valid,
    output logic                        in_control_ready,
    output logic                        out_control_done,
    output logic                        out_control_full,
    output logic                        rd_en_b,
    output flow_table_pkg::ft_addr_t    addr_b [`FT_WAYS],
    output flow_table_pkg::way_mask_t   wr_en_b,
    output flow_fields_pkg::tuple_t     wr_tuple,
    output flow_fields_pkg::pcie_addr_t wr_pcie_addr,
    input  flow_table_pkg::way_mask_t   q_b_valid,
    input  flow_fields_pkg::tuple_t     q_b_tuple [`FT_WAYS],
    input  flow_fields_pkg::pcie_addr_t q_b_pcie_addr [`FT_WAYS]
);

    import flow_fields_pkg::*;
    import flow_table_pkg::*;

    localparam int               CNT_W   = $clog2(`FT_READ_LAT + 1);
    localparam logic [CNT_W-1:0] RD_LAST = CNT_W'(`FT_READ_LAT);

    place_state_t     state;
    logic             busy;
    logic             issue;
    logic [CNT_W-1:0] rd_cnt;
    hash_t            hashed [`FT_WAYS];
    way_mask_t        hashed_valid;
    tuple_t           ctl_tuple_d [`FT_HASH_STAGES];
    pcie_addr_t       ctl_pcie_d [`FT_HASH_STAGES];
    way_mask_t        hit;
    way_mask_t        hit_r;
    way_mask_t        empty_r;

    function automatic way_mask_t lowest_way(way_mask_t mask);
        return mask & (~mask + 1'b1);
    endfunction

    assign busy             = (state != PL_IDLE);
    assign in_control_ready = !busy;
    assign issue            = !busy && (&hashed_valid);

    for (genvar w = 0; w < `FT_WAYS; w++) begin : g_way
        flow_hash #(.SEED(w)) hash_i (
            .clk          (clk),
            .rst          (rst),
            .stall        (busy),
            .tuple_in     (in_control_tuple),
            .tuple_valid  (in_control_valid && in_control_ready),
            .hashed       (hashed[w]),
            .hashed_valid (hashed_valid[w])
        );
        // Entry being placed is held in wr_tuple for the whole operation
        assign hit[w] = q_b_valid[w] && (q_b_tuple[w] == wr_tuple);
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            ctl_tuple_d[0] <= in_control_tuple;
            ctl_pcie_d[0]  <= in_control_pcie_addr;
            for (int i = 1; i < `FT_HASH_STAGES; i++) begin
                ctl_tuple_d[i] <= ctl_tuple_d[i-1];
                ctl_pcie_d[i]  <= ctl_pcie_d[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            wr_tuple     <= ctl_tuple_d[`FT_HASH_STAGES-1];
            wr_pcie_addr <= ctl_pcie_d[`FT_HASH_STAGES-1];
            for (int w = 0; w < `FT_WAYS; w++) begin
                addr_b[w] <= hashed[w][`FT_HASH_W-1 -: `FT_AWIDTH];
            end
        end
        if (state == PL_READ && rd_cnt == RD_LAST) begin
            hit_r   <= hit;
            empty_r <= ~q_b_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= PL_IDLE;
            rd_en_b          <= 1'b0;
            wr_en_b          <= '0;
            out_control_done <= 1'b0;
            out_control_full <= 1'b0;
            rd_cnt           <= '0;
        end else begin
            rd_en_b          <= issue;
            wr_en_b          <= '0;
            out_control_done <= 1'b0;
            out_control_full <= 1'b0;
            case (state)
                PL_IDLE: begin
                    if (issue) begin
                        rd_cnt <= '0;
                        state  <= PL_READ;
                    end
                end
                PL_READ: begin
                    if (rd_cnt != RD_LAST) begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end else if (|hit) begin
                        state <= PL_UPDATE;
                    end else if (!(&q_b_valid)) begin
                        state <= PL_INSERT;
                    end else begin
                        state <= PL_FULL;
                    end
                end
                PL_UPDATE: begin
                    wr_en_b          <= lowest_way(hit_r);
                    out_control_done <= 1'b1;
                    state            <= PL_IDLE;
                end
                PL_INSERT: begin
                    wr_en_b          <= lowest_way(empty_r);
                    out_control_done <= 1'b1;
                    state            <= PL_IDLE;
                end
                PL_FULL: begin
                    // No eviction, the entry is dropped
                    out_control_done <= 1'b1;
                    out_control_full <= 1'b1;
                    state            <= PL_IDLE;
                end
                default: begin
                    state <= PL_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hw/flow_table_top.sv ====
`timescale 1ns/1ps
`include "flow_table_defs.svh"

module flow_table_top (
    input  logic                        clk,
    input  logic                        rst,
    input  flow_fields_pkg::tuple_t     in_meta_tuple,
    input  flow_fields_pkg::pkt_len_t   in_meta_len,
    input  logic                        in_meta_valid,
    output logic                        in_meta_ready,
    output flow_fields_pkg::tuple_t     out_meta_tuple,
    output flow_fields_pkg::pkt_len_t   out_meta_len,
    output flow_fields_pkg::pcie_addr_t out_meta_pcie_addr,
    output logic                        out_meta_valid,
    input  flow_fields_pkg::tuple_t     in_control_tuple,
    input  flow_fields_pkg::pcie_addr_t in_control_pcie_addr,
    input  logic                        in_control_valid,
    output logic                        in_control_ready,
    output logic                        out_control_done,
    output logic                        out_control_full
);

    import flow_fields_pkg::*;
    import flow_table_pkg::*;

    logic       rd_en_a;
    logic       rd_en_b;
    ft_addr_t   addr_a [`FT_WAYS];
    ft_addr_t   addr_b [`FT_WAYS];
    way_mask_t  wr_en_b;
    tuple_t     wr_tuple;
    pcie_addr_t wr_pcie_addr;
    way_mask_t  q_a_valid;
    way_mask_t  q_b_valid;
    tuple_t     q_a_tuple [`FT_WAYS];
    tuple_t     q_b_tuple [`FT_WAYS];
    pcie_addr_t q_a_pcie_addr [`FT_WAYS];
    pcie_addr_t q_b_pcie_addr [`FT_WAYS];

    flow_lookup lookup_i (
        .clk                (clk),
        .rst                (rst),
        .in_meta_tuple      (in_meta_tuple),
        .in_meta_len        (in_meta_len),
        .in_meta_valid      (in_meta_valid),
        .in_meta_ready      (in_meta_ready),
        .out_meta_tuple     (out_meta_tuple),
        .out_meta_len       (out_meta_len),
        .out_meta_pcie_addr (out_meta_pcie_addr),
        .out_meta_valid     (out_meta_valid),
        .rd_en_a            (rd_en_a),
        .addr_a             (addr_a),
        .q_a_valid          (q_a_valid),
        .q_a_tuple          (q_a_tuple),
        .q_a_pcie_addr      (q_a_pcie_addr)
    );

    flow_placement placement_i (
        .clk                  (clk),
        .rst                  (rst),
        .in_control_tuple     (in_control_tuple),
        .in_control_pcie_addr (in_control_pcie_addr),
        .in_control_valid     (in_control_valid),
        .in_control_ready     (in_control_ready),
        .out_control_done     (out_control_done),
        .out_control_full     (out_control_full),
        .rd_en_b              (rd_en_b),
        .addr_b               (addr_b),
        .wr_en_b              (wr_en_b),
        .wr_tuple             (wr_tuple),
        .wr_pcie_addr         (wr_pcie_addr),
        .q_b_valid            (q_b_valid),
        .q_b_tuple            (q_b_tuple),
        .q_b_pcie_addr        (q_b_pcie_addr)
    );

    // Port a serves lookups, port b serves placement
    for (genvar w = 0; w < `FT_WAYS; w++) begin : g_sub
        flow_subtable subtable_i (
            .clk           (clk),
            .rst           (rst),
            .addr_a        (addr_a[w]),
            .addr_b        (addr_b[w]),
            .rd_en_a       (rd_en_a),
            .rd_en_b       (rd_en_b),
            .wr_en_b       (wr_en_b[w]),
            .wr_tuple      (wr_tuple),
            .wr_pcie_addr  (wr_pcie_addr),
            .q_a_valid     (q_a_valid[w]),
            .q_b_valid     (q_b_valid[w]),
            .q_a_tuple     (q_a_tuple[w]),
            .q_b_tuple     (q_b_tuple[w]),
            .q_a_pcie_addr (q_a_pcie_addr[w]),
            .q_b_pcie_addr (q_b_pcie_addr[w])
        );
    end

endmodule

// ==== dv/flow_table_tb.sv ====
`timescale 1ns/1ps
`include "flow_table_defs.svh"

module flow_table_tb;

    import flow_fields_pkg::*;
    import flow_table_pkg::*;

    localparam int          POOL_N      = 8;
    localparam int          RAND_OPS    = 200;
    localparam int          READY_LIMIT = 200;
    // Random phase costs about 13 cycles per insert, directed tests a few hundred
    localparam int          MAX_CYCLES  = 20000;
    localparam logic [31:0] RAND_SEED   = 32'hcf03cfe9;

    logic       clk = 1'b0;
    logic       rst;
    tuple_t     in_meta_tuple;
    pkt_len_t   in_meta_len;
    logic       in_meta_valid;
    logic       in_meta_ready;
    tuple_t     out_meta_tuple;
    pkt_len_t   out_meta_len;
    pcie_addr_t out_meta_pcie_addr;
    logic       out_meta_valid;
    tuple_t     in_control_tuple;
    pcie_addr_t in_control_pcie_addr;
    logic       in_control_valid;
    logic       in_control_ready;
    logic       out_control_done;
    logic       out_control_full;

    // Reference table
    tuple_t     m_tuple [`FT_WAYS][`FT_DEPTH];
    pcie_addr_t m_addr [`FT_WAYS][`FT_DEPTH];
    logic       m_valid [`FT_WAYS][`FT_DEPTH];

    // At most one write in flight, placements are several cycles apart
    logic       pend_valid;
    int         pend_way;
    ft_addr_t   pend_slot;
    tuple_t     pend_tuple;
    pcie_addr_t pend_addr;
    int         pend_at;
    int         neg_idx;
    int         cycles = 0;

    tuple_t     lk_tuple_q [$];
    pkt_len_t   lk_len_q [$];
    tuple_t     ct_tuple_q [$];
    pcie_addr_t ct_addr_q [$];

    tuple_t     exp_tuple;
    pkt_len_t   exp_len;
    pcie_addr_t exp_addr;
    logic       exp_full;
    string      test_name;

    tuple_t     mon_tuple;
    pcie_addr_t mon_addr;
    tuple_t     ta;
    tuple_t     base;
    tuple_t     set_t [1:5];
    tuple_t     pool [POOL_N];
    int         li;
    int         ci;

    flow_table_top dut_i (
        .clk                  (clk),
        .rst                  (rst),
        .in_meta_tuple        (in_meta_tuple),
        .in_meta_len          (in_meta_len),
        .in_meta_valid        (in_meta_valid),
        .in_meta_ready        (in_meta_ready),
        .out_meta_tuple       (out_meta_tuple),
        .out_meta_len         (out_meta_len),
        .out_meta_pcie_addr   (out_meta_pcie_addr),
        .out_meta_valid       (out_meta_valid),
        .in_control_tuple     (in_control_tuple),
        .in_control_pcie_addr (in_control_pcie_addr),
        .in_control_valid     (in_control_valid),
        .in_control_ready     (in_control_ready),
        .out_control_done     (out_control_done),
        .out_control_full     (out_control_full)
    );

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            abort_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    // Fold, multiply, shift-xor, multiply; slot is the top bits
    function automatic ft_addr_t slot_of(input tuple_t t, input int way);
        logic [4*`FT_HASH_W-1:0] padded;
        hash_t                   h;
        padded = {{(4*`FT_HASH_W - `FT_TUPLE_W){1'b0}}, t};
        h = hash_t'(way);
        for (int i = 0; i < 4; i++) begin
            h = h ^ padded[i*`FT_HASH_W +: `FT_HASH_W];
        end
        h = h * `FT_HASH_MULT;
        h = h ^ (h >> 16);
        h = h * `FT_HASH_MULT;
        return h[`FT_HASH_W-1 -: `FT_AWIDTH];
    endfunction

    // Hit way first, then lowest empty way, -1 for a full set
    function automatic int pick_way(input tuple_t t);
        ft_addr_t s;
        for (int w = 0; w < `FT_WAYS; w++) begin
            s = slot_of(t, w);
            if (m_valid[w][s] && m_tuple[w][s] == t) begin
                return w;
            end
        end
        for (int w = 0; w < `FT_WAYS; w++) begin
            s = slot_of(t, w);
            if (!m_valid[w][s]) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic pcie_addr_t lookup_ref(input tuple_t t);
        ft_addr_t s;
        for (int w = 0; w < `FT_WAYS; w++) begin
            s = slot_of(t, w);
            if (m_valid[w][s] && m_tuple[w][s] == t) begin
                return m_addr[w][s];
            end
        end
        return '0;
    endfunction

    function automatic logic set_free(input tuple_t t);
        for (int w = 0; w < `FT_WAYS; w++) begin
            if (m_valid[w][slot_of(t, w)]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    function automatic tuple_t rand_tuple();
        return tuple_t'({$urandom(), $urandom(), $urandom(), $urandom()});
    endfunction

    // Same fold for every k, so all ways hash to the same slots
    function automatic tuple_t twin_of(input tuple_t b, input int k);
        return b ^ (tuple_t'(k) << `FT_HASH_W) ^ tuple_t'(k);
    endfunction

    task automatic clear_model();
        for (int w = 0; w < `FT_WAYS; w++) begin
            for (int s = 0; s < `FT_DEPTH; s++) begin
                m_valid[w][s] = 1'b0;
            end
        end
        pend_valid = 1'b0;
        neg_idx    = 0;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            clear_model();
        end else begin
            if (pend_valid && neg_idx >= pend_at) begin
                m_tuple[pend_way][pend_slot] = pend_tuple;
                m_addr[pend_way][pend_slot]  = pend_addr;
                m_valid[pend_way][pend_slot] = 1'b1;
                pend_valid = 1'b0;
            end
            if (out_control_done) begin
                if (ct_tuple_q.size() == 0) begin
                    abort_run("out_control_done pulsed with no control entry pending");
                end else begin
                    mon_tuple = ct_tuple_q.pop_front();
                    mon_addr  = ct_addr_q.pop_front();
                    pend_way  = pick_way(mon_tuple);
                    exp_full  = (pend_way < 0);
                    if (!exp_full) begin
                        // Write edge follows done; lookups read one edge before their pulse
                        pend_valid = 1'b1;
                        pend_slot  = slot_of(mon_tuple, pend_way);
                        pend_tuple = mon_tuple;
                        pend_addr  = mon_addr;
                        pend_at    = neg_idx + 3;
                    end
                end
            end
            if (out_meta_valid) begin
                if (lk_tuple_q.size() == 0) begin
                    abort_run("out_meta_valid pulsed with no lookup pending");
                end else begin
                    exp_tuple = lk_tuple_q.pop_front();
                    exp_len   = lk_len_q.pop_front();
                    exp_addr  = lookup_ref(exp_tuple);
                end
            end
            neg_idx++;
        end
    end

    // Checked on the edge that ends each pulse, expectations set half a cycle before
    meta_tuple_chk: assert property (@(posedge clk) disable iff (rst)
        out_meta_valid |-> out_meta_tuple == exp_tuple)
        else abort_run($sformatf("Error %s: out_meta_tuple expected %h actual %h",
                                 test_name, exp_tuple, $sampled(out_meta_tuple)));

    meta_len_chk: assert property (@(posedge clk) disable iff (rst)
        out_meta_valid |-> out_meta_len == exp_len)
        else abort_run($sformatf("Error %s: out_meta_len expected %h actual %h",
                                 test_name, exp_len, $sampled(out_meta_len)));

    meta_addr_chk: assert property (@(posedge clk) disable iff (rst)
        out_meta_valid |-> out_meta_pcie_addr == exp_addr)
        else abort_run($sformatf("Error %s: out_meta_pcie_addr expected %h actual %h",
                                 test_name, exp_addr, $sampled(out_meta_pcie_addr)));

    ctrl_full_chk: assert property (@(posedge clk) disable iff (rst)
        out_control_done |-> out_control_full == exp_full)
        else abort_run($sformatf("Error %s: out_control_full expected %b actual %b",
                                 test_name, exp_full, $sampled(out_control_full)));

    meta_pulse_chk: assert property (@(posedge clk) disable iff (rst)
        out_meta_valid |=> !out_meta_valid)
        else abort_run("out_meta_valid stayed high for more than one cycle");

    done_pulse_chk: assert property (@(posedge clk) disable iff (rst)
        out_control_done |=> !out_control_done)
        else abort_run("out_control_done stayed high for more than one cycle");

    full_alone_chk: assert property (@(posedge clk) disable iff (rst)
        out_control_full |-> out_control_done)
        else abort_run("out_control_full was raised without out_control_done");

    // Called at a falling edge; ready only moves on rising edges
    task automatic send_meta(input tuple_t t, input pkt_len_t len);
        int waited;
        waited        = 0;
        in_meta_tuple = t;
        in_meta_len   = len;
        in_meta_valid = 1'b1;
        while (!in_meta_ready) begin
            waited++;
            if (waited > READY_LIMIT) begin
                abort_run("in_meta_ready stayed low far longer than any lookup takes");
            end
            @(negedge clk);
        end
        lk_tuple_q.push_back(t);
        lk_len_q.push_back(len);
        @(negedge clk);
        in_meta_valid = 1'b0;
    endtask

    task automatic send_ctrl(input tuple_t t, input pcie_addr_t addr);
        int waited;
        waited               = 0;
        in_control_tuple     = t;
        in_control_pcie_addr = addr;
        in_control_valid     = 1'b1;
        while (!in_control_ready) begin
            waited++;
            if (waited > READY_LIMIT) begin
                abort_run("in_control_ready stayed low far longer than any placement takes");
            end
            @(negedge clk);
        end
        ct_tuple_q.push_back(t);
        ct_addr_q.push_back(addr);
        @(negedge clk);
        in_control_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (lk_tuple_q.size() != 0 || ct_tuple_q.size() != 0 || pend_valid) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        rst                  = 1'b1;
        in_meta_tuple        = '0;
        in_meta_len          = '0;
        in_meta_valid        = 1'b0;
        in_control_tuple     = '0;
        in_control_pcie_addr = '0;
        in_control_valid     = 1'b0;
        test_name            = "reset";
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_name = "empty_lookup";
        ta = rand_tuple();
        send_meta(ta, 16'd64);
        wait_idle();

        test_name = "insert_lookup";
        send_ctrl(ta, 64'h0000_1000_0000_0040);
        wait_idle();
        send_meta(ta, 16'd1500);
        wait_idle();

        test_name = "update_existing";
        send_ctrl(ta, 64'h0000_2000_0000_0080);
        wait_idle();
        send_meta(ta, 16'd128);
        wait_idle();
        // Three twins fit in the set only if the update kept to one way
        for (int k = 1; k <= 3; k++) begin
            send_ctrl(twin_of(ta, k), pcie_addr_t'(k) << 8);
            wait_idle();
        end

        test_name = "full_set";
        base = rand_tuple();
        while (!set_free(base)) begin
            base = base + 1'b1;
        end
        for (int k = 1; k <= 5; k++) begin
            set_t[k] = twin_of(base, k);
            for (int w = 0; w < `FT_WAYS; w++) begin
                assert (slot_of(set_t[k], w) == slot_of(base, w))
                    else abort_run("Colliding tuples do not share a slot in every way");
            end
        end
        for (int k = 1; k <= 4; k++) begin
            send_ctrl(set_t[k], pcie_addr_t'(k) << 12);
            wait_idle();
        end
        send_ctrl(set_t[5], 64'hdead_0000_0000_5000);
        wait_idle();
        send_meta(set_t[5], 16'd40);
        for (int k = 1; k <= 4; k++) begin
            send_meta(set_t[k], pkt_len_t'(k));
        end
        wait_idle();

        test_name = "random_mixed";
        base = rand_tuple();
        for (int i = 0; i < POOL_N; i++) begin
            // First five share one set, so updates and full sets both occur
            if (i < 5) begin
                pool[i] = twin_of(base, i + 1);
            end else begin
                pool[i] = rand_tuple();
            end
        end
        fork
            begin
                repeat (RAND_OPS) begin
                    repeat ($urandom % 4) @(negedge clk);
                    li = int'($urandom % POOL_N);
                    send_meta(pool[li], pkt_len_t'($urandom));
                end
            end
            begin
                repeat (RAND_OPS) begin
                    repeat ($urandom % 4) @(negedge clk);
                    ci = int'($urandom % POOL_N);
                    send_ctrl(pool[ci], {$urandom(), $urandom()});
                end
            end
        join
        wait_idle();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
hw/flow_fields_pkg.sv
hw/flow_table_pkg.sv
hw/flow_hash.sv
hw/flow_subtable.sv
hw/flow_lookup.sv
hw/flow_placement.sv
hw/flow_table_top.sv
dv/flow_table_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the flow table testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f sources.f \
    --top-module flow_table_tb \
    -Mdir obj_dir -o flow_table_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/flow_table_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1
